// File: common/rvPkg.sv
/* Shared widths, opcodes, controller states and datapath select encodings for the RV32I core.
   Only the RV32I base set is encoded; there are no CSR or SYSTEM opcodes. */
package rvPkg;

  localparam int dataWidth = 32;

  typedef logic [dataWidth-1:0] dataT;

  localparam dataT resetPc = '0;  // first fetch address

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opFence  = 7'b0001111,
    opIType  = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opRType  = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeT;

  // controller states
  typedef enum logic [4:0] {
    stFetch,
    stFetchWait,
    stDecode,
    stExecuteR,
    stExecuteI,
    stUncondJump,
    stMemAdr,
    stAluWb,
    stMemWrite,
    stMemRead,
    stMemWb,
    stBranchIfEq,
    stLui,
    stAuipc,
    stJalrCalc,
    stJalrStep2,
    stBranchComp
  } ctrlStateT;

  typedef enum logic {adrPc, adrAluResult} adrSrcT;

  // pcAluMasked takes the registered rs1+imm of a JALR with bit 0 cleared
  typedef enum logic [1:0] {pcIncrement, pcJump, pcAluMasked} pcSrcT;

  typedef enum logic [1:0] {srcAOldPc, srcAZero, srcARs1} aluSrcAT;
  typedef enum logic [1:0] {srcBImm, srcBRs2, srcBFour} aluSrcBT;
  typedef enum logic [1:0] {resAluOut, resAluResult, resMemData} resultSrcT;

  typedef enum logic [1:0] {aluAdd, aluBranch, aluDecode} aluOpT;

endpackage

// File: hw/control/controlFsm.sv
/* Moore controller for the multicycle core; an unknown opcode parks it in decode for good.
   Memory reads are assumed to return one cycle after the address is presented. */
module controlFsm (
  input  logic              clk,
  input  logic              reset,
  input  rvPkg::opcodeT     opcode,
  input  logic [2:0]        funct3,
  input  logic              zero,
  input  rvPkg::dataT       aluResult,
  input  logic [3:0]        byteEnable,
  output rvPkg::adrSrcT     adrSrc,
  output logic              irWrite,
  output logic              regWrite,
  output logic              pcUpdate,
  output rvPkg::pcSrcT      pcSrc,
  output logic [3:0]        memWrite,
  output rvPkg::aluSrcAT    aluSrcA,
  output rvPkg::aluSrcBT    aluSrcB,
  output rvPkg::resultSrcT  resultSrc,
  output rvPkg::aluOpT      aluOp
);
  import rvPkg::*;

  ctrlStateT state, nextState;
  logic      lessThan;

  assign lessThan = (aluResult == dataT'(1));  // slt/sltu output from the alu

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stFetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = stFetch;
    case (state)
      stFetch:     nextState = stFetchWait;
      stFetchWait: nextState = stDecode;
      stDecode: begin
        case (opcode)
          opRType:         nextState = stExecuteR;
          opIType:         nextState = stExecuteI;
          opLoad, opStore: nextState = stMemAdr;
          opBranch:        nextState = (funct3[2:1] == 2'b00) ? stBranchIfEq : stBranchComp;
          opJal:           nextState = stUncondJump;
          opJalr:          nextState = stJalrCalc;
          opLui:           nextState = stLui;
          opAuipc:         nextState = stAuipc;
          opFence:         nextState = stFetch;   // no-op
          default:         nextState = stDecode;  // halt
        endcase
      end
      stMemAdr:    nextState = (opcode == opStore) ? stMemWrite : stMemRead;
      stMemRead:   nextState = stMemWb;
      stJalrCalc:  nextState = stJalrStep2;
      stExecuteR, stExecuteI, stUncondJump, stLui, stAuipc, stJalrStep2: begin
        nextState = stAluWb;
      end
      default:     nextState = stFetch;  // writeback, store and branch states
    endcase
  end

  always_comb begin
    adrSrc    = adrPc;
    irWrite   = 1'b0;
    regWrite  = 1'b0;
    pcUpdate  = 1'b0;
    pcSrc     = pcIncrement;
    memWrite  = 4'b0000;
    aluSrcA   = srcAOldPc;
    aluSrcB   = srcBImm;
    resultSrc = resAluOut;
    aluOp     = aluAdd;
    case (state)
      stFetchWait: begin
        irWrite  = 1'b1;  // instruction word is on memRData now
        pcUpdate = 1'b1;
      end
      stDecode: ;  // alu forms oldPc + imm as the branch/jal target
      stExecuteR: begin
        aluSrcA = srcARs1;
        aluSrcB = srcBRs2;
        aluOp   = aluDecode;
      end
      stExecuteI: begin
        aluSrcA = srcARs1;
        aluOp   = aluDecode;
      end
      stLui: aluSrcA = srcAZero;
      stUncondJump, stJalrStep2: begin
        aluSrcB  = srcBFour;  // link value oldPc + 4
        pcUpdate = 1'b1;
        pcSrc    = (state == stJalrStep2) ? pcAluMasked : pcJump;
      end
      stJalrCalc: aluSrcA = srcARs1;
      stMemAdr: begin
        aluSrcA   = srcARs1;
        adrSrc    = adrAluResult;
        resultSrc = resAluResult;
      end
      stMemRead, stMemWrite: begin
        aluSrcA  = srcARs1;  // keep the address on the alu
        adrSrc   = adrAluResult;
        memWrite = (state == stMemWrite) ? byteEnable : 4'b0000;
      end
      stMemWb: begin
        resultSrc = resMemData;
        regWrite  = 1'b1;
      end
      stAluWb: regWrite = 1'b1;
      stBranchIfEq, stBranchComp: begin
        aluSrcA  = srcARs1;
        aluSrcB  = srcBRs2;
        aluOp    = aluBranch;
        pcSrc    = pcJump;
        // funct3[0] flips the sense for bne, bge and bgeu
        pcUpdate = ((state == stBranchIfEq) ? zero : lessThan) ^ funct3[0];
      end
      default: ;  // stFetch and stAuipc use the defaults
    endcase
  end

  // signed and unsigned branches need a 0/1 compare flag from the alu
  compareFlag: assert property (@(posedge clk) disable iff (reset)
    (state == stBranchComp) |-> (aluResult[dataWidth-1:1] == '0));

  // a store writes one byte, an aligned half or the whole word
  storeLanes: assert property (@(posedge clk) disable iff (reset)
    (state == stMemWrite) |-> (memWrite inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                4'b0011, 4'b1100, 4'b1111}));

endmodule

// File: hw/datapath/aluUnit.sv
/* Combinational ALU; branch mode only distinguishes eq/ne, signed and unsigned compares.
   Shift amounts use the low five bits of b. */
module aluUnit (
  input  rvPkg::aluOpT  aluOp,
  input  logic [2:0]    funct3,
  input  logic          funct7b5,
  input  logic          isRType,
  input  rvPkg::dataT   a,
  input  rvPkg::dataT   b,
  output rvPkg::dataT   result,
  output logic          zero
);
  import rvPkg::*;

  dataT sltRes, sltuRes;

  assign sltRes  = dataT'($signed(a) < $signed(b));
  assign sltuRes = dataT'(a < b);

  always_comb begin
    result = a + b;
    case (aluOp)
      aluBranch: begin
        case (funct3[2:1])
          2'b00:   result = a - b;  // beq, bne use zero
          2'b10:   result = sltRes;
          default: result = sltuRes;
        endcase
      end
      aluDecode: begin
        case (funct3)
          3'b000:  result = (isRType && funct7b5) ? a - b : a + b;
          3'b001:  result = a << b[4:0];
          3'b010:  result = sltRes;
          3'b011:  result = sltuRes;
          3'b100:  result = a ^ b;
          3'b101:  result = funct7b5 ? dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'b110:  result = a | b;
          default: result = a & b;
        endcase
      end
      default: ;  // add
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: hw/datapath/regFile.sv
/* 32 x 32 register file, two combinational reads and one write per clock.
   x0 reads as zero and ignores writes. */
module regFile (
  input  logic         clk,
  input  logic         we,
  input  logic [4:0]   ra1,
  input  logic [4:0]   ra2,
  input  logic [4:0]   wa,
  input  rvPkg::dataT  wd,
  output rvPkg::dataT  rd1,
  output rvPkg::dataT  rd2
);
  import rvPkg::*;

  dataT regs [32];

  always_ff @(posedge clk) begin
    if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // no bypass, a write is visible the cycle after
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: hw/datapath/immExtend.sv
/* Immediate generator, format chosen from the opcode field; anything unlisted is I-type. */
module immExtend (
  input  rvPkg::dataT  instr,
  output rvPkg::dataT  immExt
);
  import rvPkg::*;

  opcodeT opcode;

  assign opcode = opcodeT'(instr[6:0]);

  always_comb begin
    case (opcode)
      opStore: begin
        immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      opBranch: begin
        immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      opLui, opAuipc: begin
        immExt = {instr[31:12], 12'b0};  // already in the upper bits
      end
      opJal: begin
        immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        immExt = {{20{instr[31]}}, instr[31:20]};  // loads, jalr, alu immediates
      end
    endcase
  end

endmodule

// File: hw/datapath/loadStoreAlign.sv
/* Byte-lane steering for loads and stores; addresses must be naturally aligned.
   Store data is replicated across all lanes, the enables pick the lanes written. */
module loadStoreAlign (
  input  logic [2:0]   funct3,
  input  logic [1:0]   addrLow,
  input  rvPkg::dataT  storeData,
  input  rvPkg::dataT  memRData,
  output logic [3:0]   byteEnable,
  output rvPkg::dataT  memWData,
  output rvPkg::dataT  loadData
);
  import rvPkg::*;

  dataT laneData;

  always_comb begin
    case (funct3[1:0])
      2'b00: begin  // sb
        byteEnable = 4'b0001 << addrLow;
        memWData   = {4{storeData[7:0]}};
      end
      2'b01: begin  // sh
        byteEnable = addrLow[1] ? 4'b1100 : 4'b0011;
        memWData   = {2{storeData[15:0]}};
      end
      default: begin
        byteEnable = 4'b1111;
        memWData   = storeData;
      end
    endcase
  end

  assign laneData = memRData >> {addrLow, 3'b000};  // addressed byte/half to bit 0

  always_comb begin
    case (funct3)
      3'b000:  loadData = {{24{laneData[7]}}, laneData[7:0]};
      3'b100:  loadData = {24'b0, laneData[7:0]};
      3'b001:  loadData = {{16{laneData[15]}}, laneData[15:0]};
      3'b101:  loadData = {16'b0, laneData[15:0]};
      default: loadData = memRData;  // lw
    endcase
  end

endmodule

// File: hw/rvCore.sv
/* Multicycle RV32I core on one memory port with registered reads and byte write enables.
   No traps or CSRs; misaligned addresses are not detected. */
module rvCore (
  input  logic         clk,
  input  logic         reset,
  output rvPkg::dataT  memAddr,
  output rvPkg::dataT  memWData,
  output logic [3:0]   memWe,
  input  rvPkg::dataT  memRData
);
  import rvPkg::*;

  dataT       pc, oldPc, instr, aluOut, dataReg;
  dataT       pcNext, srcA, srcB, aluResult, immExt, rd1, rd2, result, loadData;
  logic       zero;
  logic [3:0] byteEnable;
  opcodeT     opcode;

  adrSrcT     adrSrc;
  pcSrcT      pcSrc;
  aluSrcAT    aluSrcA;
  aluSrcBT    aluSrcB;
  resultSrcT  resultSrc;
  aluOpT      aluOp;
  logic       irWrite, regWrite, pcUpdate;
  logic [3:0] memWrite;

  assign opcode = opcodeT'(instr[6:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= resetPc;
    end else if (pcUpdate) begin
      pc <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    if (irWrite) begin
      instr <= memRData;
      oldPc <= pc;  // pc of the instruction being executed
    end
    aluOut  <= aluResult;
    dataReg <= memRData;
  end

  always_comb begin
    case (pcSrc)
      pcJump:      pcNext = aluOut;
      pcAluMasked: pcNext = {aluOut[dataWidth-1:1], 1'b0};  // jalr target
      default:     pcNext = pc + dataT'(4);
    endcase
    case (aluSrcA)
      srcARs1:  srcA = rd1;
      srcAZero: srcA = '0;
      default:  srcA = oldPc;
    endcase
    case (aluSrcB)
      srcBRs2:  srcB = rd2;
      srcBFour: srcB = dataT'(4);
      default:  srcB = immExt;
    endcase
    case (resultSrc)
      resAluResult: result = aluResult;
      resMemData:   result = loadData;
      default:      result = aluOut;
    endcase
  end

  assign memAddr = (adrSrc == adrAluResult) ? aluResult : pc;
  assign memWe   = memWrite;

  controlFsm i_controlFsm (
    .clk, .reset, .opcode, .funct3(instr[14:12]), .zero, .aluResult, .byteEnable,
    .adrSrc, .irWrite, .regWrite, .pcUpdate, .pcSrc, .memWrite,
    .aluSrcA, .aluSrcB, .resultSrc, .aluOp
  );

  aluUnit i_aluUnit (
    .aluOp, .funct3(instr[14:12]), .funct7b5(instr[30]), .isRType(opcode == opRType),
    .a(srcA), .b(srcB), .result(aluResult), .zero
  );

  regFile i_regFile (
    .clk, .we(regWrite), .ra1(instr[19:15]), .ra2(instr[24:20]), .wa(instr[11:7]),
    .wd(result), .rd1, .rd2
  );

  immExtend i_immExtend (.instr, .immExt);

  // aluOut holds the data address from MemAdr on through MemWrite and MemWb
  loadStoreAlign i_loadStoreAlign (
    .funct3(instr[14:12]), .addrLow(aluOut[1:0]), .storeData(rd2), .memRData(dataReg),
    .byteEnable, .memWData, .loadData
  );

  pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: dv/tbRvCore.sv
/* Random-program testbench for rvCore, with a 4 KiB registered-read memory and an ISA model.
   Fetches are seen through the controller state, and each program ends on an all-zero word. */
module tbRvCore;
  import rvPkg::*;

  localparam int numTests   = 8;
  localparam int idleCycles = 32;  // quiet window after the halt
  localparam int memWords   = 1024;

  logic       clk, reset;
  dataT       memAddr, memWData, memRData;
  logic [3:0] memWe;

  dataT        mem [memWords];
  dataT        modelMem [memWords];
  dataT        modelReg [32];
  logic [31:0] lfsr;
  logic [9:0]  prevIdx;
  int          progLen, cycle, lastFetch, resetFall, fetchIdx, storeIdx, errors, failed;
  dataT        expFetch[$], expStAddr[$], expStData[$];
  logic [3:0]  expStBe[$];
  int          expCycles[$];

  rvCore i_dut (.clk, .reset, .memAddr, .memWData, .memWe, .memRData);

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [4:0] pickReg();
    return 5'(randBits(3) % 7 + 1);  // x1..x7 only since x8 and x9 hold the bases
  endfunction

  function automatic logic [4:0] pickSrc();
    return 5'(randBits(3));
  endfunction

  function automatic dataT fillWord(int i);
    return dataT'(i * 4) * 32'h9e3779b1;
  endfunction

  function automatic dataT iFormat(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};  // also R-type with {funct7, rs2} as imm
  endfunction

  function automatic dataT sFormat(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic dataT bFormat(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic dataT jFormat(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic dataT uFormat(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic dataT aluRef(logic [2:0] f3, logic alt, dataT a, dataT b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return dataT'($signed(a) < $signed(b));
      3'd3:    return dataT'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(logic [2:0] f3, dataT a, dataT b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic compareAddr(string name, dataT act, dataT exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compareData(string name, dataT act, dataT exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compareByteEnable(string name, logic [3:0] act, logic [3:0] exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compareCycles(string name, int act, int exp);
    if (act != exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic reportFailure(string msg);
    $display("at time %0t the core failed: %s", $time, msg);
    errors++;
  endtask

  task automatic emit(dataT w);
    mem[progLen]      = w;
    modelMem[progLen] = w;
    progLen++;
  endtask

  task automatic emitFiller();
    emit(iFormat(12'(randBits(12)), pickSrc(), 3'b000, pickReg(), opIType));
  endtask

  function automatic logic [11:0] dataOffset(logic [1:0] size);
    logic [11:0] off;
    off = 12'(randBits(6)) << 2;
    if (size == 2'd0) off += 12'(randBits(2));
    if (size == 2'd1) off += 12'(randBits(1)) << 1;
    return off;
  endfunction

  task automatic genProgram();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [11:0] imm;
    logic        alt;
    int          idx;
    for (int i = 0; i < memWords; i++) begin
      mem[i]      = (i >= 256 && i < 384) ? randBits(32) : fillWord(i);  // data at 0x400
      modelMem[i] = mem[i];
    end
    progLen = 0;
    for (int r = 1; r < 8; r++) begin
      emit(uFormat(20'(randBits(20)), 5'(r), opLui));
      emit(iFormat(12'(randBits(12)), 5'(r), 3'b000, 5'(r), opIType));
    end
    emit(iFormat(12'h400, 5'd0, 3'b000, 5'd8, opIType));  // data base
    emit(iFormat(12'h600, 5'd0, 3'b000, 5'd9, opIType));  // dump base
    while (progLen < 48) begin
      rd = pickReg();
      f3 = 3'(randBits(3));
      case (3'(randBits(3)))
        3'd0: begin
          alt = 1'(randBits(1)) && (f3 == 3'd0 || f3 == 3'd5);
          emit(iFormat({1'b0, alt, 5'b0, pickSrc()}, pickSrc(), f3, rd, opRType));
        end
        3'd1: begin
          if (f3 == 3'd1) imm = {7'b0, 5'(randBits(5))};
          else if (f3 == 3'd5) imm = {1'b0, 1'(randBits(1)), 5'b0, 5'(randBits(5))};
          else imm = 12'(randBits(12));
          emit(iFormat(imm, pickSrc(), f3, rd, opIType));
        end
        3'd2: begin
          if (f3 == 3'd7) emit(32'h0ff0000f);  // fence
          else emit(uFormat(20'(randBits(20)), rd, f3[0] ? opAuipc : opLui));
        end
        3'd3: begin
          f3 = 3'(randBits(2) % 3);
          emit(sFormat(dataOffset(f3[1:0]), pickSrc(), 5'd8, f3));
        end
        3'd4: begin
          idx = randBits(3) % 5;
          f3 = (idx > 2) ? 3'(idx + 1) : 3'(idx);  // lb lh lw lbu lhu
          emit(iFormat(dataOffset(f3[1:0]), 5'd8, f3, rd, opLoad));
        end
        3'd5: begin
          idx = randBits(3) % 6;
          f3 = (idx < 2) ? 3'(idx) : 3'(idx + 2);
          emit(bFormat(13'd8, pickSrc(), pickSrc(), f3));  // skips the filler if taken
          emitFiller();
        end
        3'd6: begin
          emit(jFormat(21'd8, rd));
          emitFiller();
        end
        default: begin
          emit(uFormat(20'd0, rd, opAuipc));
          emit(iFormat(12'd13, rd, 3'b000, pickReg(), opJalr));  // odd target that loses bit 0
          emitFiller();
        end
      endcase
    end
    for (int r = 1; r < 10; r++) begin
      emit(sFormat(12'((r - 1) * 4), 5'(r), 5'd9, 3'b010));
    end
    emit('0);
  endtask

  task automatic runModel();
    dataT       pc, nextPc, ins, a, b, res, addr, word, data;
    dataT       immI, immS, immB, immJ, immU;
    logic [3:0] be;
    logic [2:0] f3;
    logic       wb;
    int         cyc;
    int         nBytes;
    pc = resetPc;
    expFetch.delete();
    expCycles.delete();
    expStAddr.delete();
    expStBe.delete();
    expStData.delete();
    for (int n = 0; n < 256; n++) begin
      ins = modelMem[pc[11:2]];
      expFetch.push_back(pc);
      if (ins == '0) break;
      f3 = ins[14:12];
      a = modelReg[ins[19:15]];
      b = modelReg[ins[24:20]];
      immI = {{20{ins[31]}}, ins[31:20]};
      immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      immU = {ins[31:12], 12'b0};
      nextPc = pc + 4;
      res = pc + 4;  // link value
      wb = 1'b1;
      cyc = 5;
      case (ins[6:0])
        opRType: res = aluRef(f3, ins[30], a, b);
        opIType: res = aluRef(f3, (f3 == 3'd5) && ins[30], a, immI);
        opLui:   res = immU;
        opAuipc: res = pc + immU;
        opJal:   nextPc = pc + immJ;
        opJalr: begin
          nextPc = (a + immI) & ~dataT'(1);
          cyc = 6;
        end
        opBranch: begin
          wb = 1'b0;
          cyc = 4;
          if (branchTaken(f3, a, b)) nextPc = pc + immB;
        end
        opLoad: begin
          addr = a + immI;
          word = modelMem[addr[11:2]] >> {addr[1:0], 3'b000};
          case (f3)
            3'd0:    res = {{24{word[7]}}, word[7:0]};
            3'd4:    res = {24'b0, word[7:0]};
            3'd1:    res = {{16{word[15]}}, word[15:0]};
            3'd5:    res = {16'b0, word[15:0]};
            default: res = word;
          endcase
          cyc = 6;
        end
        opStore: begin
          addr = a + immS;
          wb = 1'b0;
          nBytes = 1 << f3[1:0];  // 1, 2 or 4 bytes
          be = 4'(((1 << nBytes) - 1) << addr[1:0]);
          for (int k = 0; k < 4; k++) begin
            data[8*k +: 8] = b[8*(k % nBytes) +: 8];  // low bytes repeated in every lane
          end
          for (int k = 0; k < 4; k++) begin
            if (be[k]) modelMem[addr[11:2]][8*k +: 8] = data[8*k +: 8];
          end
          expStAddr.push_back(addr);
          expStBe.push_back(be);
          expStData.push_back(data);
        end
        default: begin  // fence
          wb = 1'b0;
          cyc = 3;
        end
      endcase
      if (wb && ins[11:7] != 5'd0) modelReg[ins[11:7]] = res;
      expCycles.push_back(cyc);
      pc = nextPc;
    end
  endtask

  task automatic fetchCheck();
    if (fetchIdx == 0 && cycle - resetFall > 1) reportFailure("first fetch came late after reset");
    if (fetchIdx < expFetch.size()) begin
      compareAddr("memAddr at fetch", memAddr, expFetch[fetchIdx]);
      if (fetchIdx > 0) begin
        compareCycles("cycles per instruction", cycle - lastFetch, expCycles[fetchIdx - 1]);
      end
    end else begin
      reportFailure($sformatf("fetch from %h after the halt", memAddr));
    end
    lastFetch = cycle;
    fetchIdx++;
  endtask

  task automatic storeCheck();
    if (storeIdx < expStAddr.size()) begin
      compareAddr("memAddr at store", memAddr, expStAddr[storeIdx]);
      compareByteEnable("memWe", memWe, expStBe[storeIdx]);
      compareData("memWData", memWData, expStData[storeIdx]);
    end else begin
      reportFailure($sformatf("store to %h that the program does not make", memAddr));
    end
    storeIdx++;
  endtask

  // one falling edge that drives inputs, serves memory and watches the core
  task automatic clockCycle(logic rst);
    @(negedge clk);
    reset = rst;
    cycle++;
    memRData = mem[prevIdx];  // word addressed one cycle earlier
    for (int k = 0; k < 4; k++) begin
      if (memWe[k]) mem[memAddr[11:2]][8*k +: 8] = memWData[8*k +: 8];
    end
    prevIdx = memAddr[11:2];
    if (rst) begin
      compareByteEnable("memWe in reset", memWe, 4'b0000);
    end else begin
      if (i_dut.i_controlFsm.state == stFetch) fetchCheck();
      if (memWe != 4'b0000) storeCheck();
    end
  endtask

  task automatic runTest(int t);
    int errBefore;
    errBefore = errors;
    genProgram();
    runModel();
    fetchIdx = 0;
    storeIdx = 0;
    repeat (16) clockCycle(1'b1);
    resetFall = cycle + 1;
    while (fetchIdx < expFetch.size()) clockCycle(1'b0);
    repeat (idleCycles) clockCycle(1'b0);
    if (storeIdx != expStAddr.size()) reportFailure("some stores never appeared");
    if (errors != errBefore) failed++;
    $display("test %0d %s: %0d instructions, %0d stores, %0d errors", t,
             (errors == errBefore) ? "passed" : "failed", expFetch.size() - 1,
             expStAddr.size(), errors - errBefore);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    memRData = '0;
    prevIdx = '0;
    lfsr = 32'h5ef03947;
    errors = 0;
    failed = 0;
    cycle = 0;
    for (int r = 0; r < 32; r++) modelReg[r] = '0;
    for (int t = 0; t < numTests; t++) runTest(t);
    $display("%0d tests, %0d passed, %0d failed, %0d errors", numTests, numTests - failed,
             failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // worst case is 64 instructions of 6 cycles each with reset and idle time on top
  initial begin
    #(numTests * 64 * 6 * 4 + numTests * 400);
    $display("watchdog expired, the core stopped fetching or ran too long");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: filelist.f
common/rvPkg.sv
hw/control/controlFsm.sv
hw/datapath/aluUnit.sv
hw/datapath/regFile.sv
hw/datapath/immExtend.sv
hw/datapath/loadStoreAlign.sv
hw/rvCore.sv
dv/tbRvCore.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - common/rvPkg.sv
  - hw/control/controlFsm.sv
  - hw/datapath/aluUnit.sv
  - hw/datapath/regFile.sv
  - hw/datapath/immExtend.sv
  - hw/datapath/loadStoreAlign.sv
  - hw/rvCore.sv
  - target: simulation
    files:
      - dv/tbRvCore.sv
